// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int NUM_REGS = 32;

    typedef logic [31:0] word_t;     // Register value or operand.
    typedef logic [31:0] inst_t;     // Raw instruction word.
    typedef logic [4:0]  reg_addr_t; // Register index.
    typedef logic [2:0]  exu_cmd_t;

    // Commands from decode to execute.
    localparam exu_cmd_t CMD_NOP  = 3'd0;
    localparam exu_cmd_t CMD_ADD  = 3'd1; // Also used by lui with src2 zero.
    localparam exu_cmd_t CMD_HALT = 3'd2;

    // Major opcodes handled by the decoder.
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam inst_t INST_EBREAK = 32'h0010_0073;

    typedef enum logic {
        ST_RUN,
        ST_HALTED
    } run_state_e;

endpackage

`default_nettype wire

// ==== core_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Two register file read ports with data returned in the same cycle.
interface reg_read_if;
    import core_pkg::*;

    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;

    modport dec (
        output raddr1,
        output raddr2,
        input  rdata1,
        input  rdata2
    );

    modport rf (
        input  raddr1,
        input  raddr2,
        output rdata1,
        output rdata2
    );
endinterface

interface decode_if;
    import core_pkg::*;

    logic      valid;
    exu_cmd_t  cmd;
    word_t     src1;
    word_t     src2;
    reg_addr_t des; // Zero when nothing is written.

    modport src (output valid, output cmd, output src1, output src2, output des);
    modport snk (input valid, input cmd, input src1, input src2, input des);
endinterface

`default_nettype wire

// ==== inst_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_buffer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            inst_valid,
    input  core_pkg::inst_t inst,
    output logic            inst_ready,
    input  logic            consume,
    input  logic            halted,
    output logic            buf_valid,
    output core_pkg::inst_t buf_inst
);
    import core_pkg::*;

    logic  valid_q;
    inst_t inst_q;

    // Free slot, or the held entry leaves this cycle. Nothing enters once halted.
    assign inst_ready = (!valid_q && !halted) || consume;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (inst_ready) begin
            valid_q <= inst_valid; // Refill or drain.
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_ready) begin
            inst_q <= inst;
        end
    end

    assign buf_valid = valid_q;
    assign buf_inst  = inst_q;

endmodule

`default_nettype wire

// ==== idu.sv ====
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  logic            buf_valid,
    input  core_pkg::inst_t buf_inst,
    reg_read_if.dec         rd,
    decode_if.src           dec
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       src1_en;
    logic       src2_en;
    logic       imm_en;
    logic       imm_u;
    logic       write_en;
    exu_cmd_t   cmd;
    word_t      imm;

    assign opcode = buf_inst[6:0];
    assign funct3 = buf_inst[14:12];
    assign funct7 = buf_inst[31:25];

    always_comb begin
        cmd      = CMD_NOP;
        src1_en  = 1'b0;
        src2_en  = 1'b0;
        imm_en   = 1'b0;
        imm_u    = 1'b0;
        write_en = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin // addi
                    cmd      = CMD_ADD;
                    src1_en  = 1'b1;
                    imm_en   = 1'b1;
                    write_en = 1'b1;
                end
            end
            OPC_OP: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin // add
                    cmd      = CMD_ADD;
                    src1_en  = 1'b1;
                    src2_en  = 1'b1;
                    write_en = 1'b1;
                end
            end
            OPC_LUI: begin
                cmd      = CMD_ADD;
                imm_en   = 1'b1;
                imm_u    = 1'b1;
                write_en = 1'b1;
            end
            OPC_SYSTEM: begin
                if (buf_inst == INST_EBREAK) begin
                    cmd = CMD_HALT;
                end
            end
            default: begin
            end
        endcase
    end

    assign imm = imm_u ? {buf_inst[31:12], 12'b0} : {{20{buf_inst[31]}}, buf_inst[31:20]};

    assign rd.raddr1 = src1_en ? buf_inst[19:15] : '0;
    assign rd.raddr2 = src2_en ? buf_inst[24:20] : '0;

    // Immediate goes to src2 next to rs1 (addi), alone to src1 (lui).
    always_comb begin
        if (src1_en) begin
            dec.src1 = rd.rdata1;
        end else if (imm_en) begin
            dec.src1 = imm;
        end else begin
            dec.src1 = '0;
        end
        if (src2_en) begin
            dec.src2 = rd.rdata2;
        end else if (imm_en && src1_en) begin
            dec.src2 = imm;
        end else begin
            dec.src2 = '0;
        end
    end

    assign dec.valid = buf_valid;
    assign dec.cmd   = cmd;
    assign dec.des   = write_en ? buf_inst[11:7] : '0;

endmodule

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                clk,
    input  logic                rst_n,
    reg_read_if.rf              rd,
    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::word_t     wdata
);
    import core_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata; // x0 is never written.
        end
    end

    // Reads see the old value in the cycle of a write.
    assign rd.rdata1 = regs[rd.raddr1];
    assign rd.rdata2 = regs[rd.raddr2];

endmodule

`default_nettype wire

// ==== exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu (
    input  logic                clk,
    input  logic                rst_n,
    decode_if.snk               dec,
    output logic                consume,
    output logic                we,
    output core_pkg::reg_addr_t waddr,
    output core_pkg::word_t     wdata,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_addr,
    output core_pkg::word_t     wb_data,
    output logic                halted
);
    import core_pkg::*;

    run_state_e state;

    assign consume = dec.valid && (state == ST_RUN);

    // Only a real add with a nonzero destination writes.
    assign we    = consume && (dec.cmd == CMD_ADD) && (dec.des != '0);
    assign waddr = dec.des;
    assign wdata = dec.src1 + dec.src2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_RUN;
        end else if (consume && dec.cmd == CMD_HALT) begin
            state <= ST_HALTED; // Left only by reset.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= we;
        end
    end

    // Retire report mirrors the write of the previous cycle.
    always_ff @(posedge clk) begin
        if (we) begin
            wb_addr <= waddr;
            wb_data <= wdata;
        end
    end

    assign halted = (state == ST_HALTED);

endmodule

`default_nettype wire

// ==== core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  core_pkg::inst_t     inst,
    output logic                inst_ready,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_addr,
    output core_pkg::word_t     wb_data,
    output logic                halted
);
    import core_pkg::*;

    logic      buf_valid;
    inst_t     buf_inst;
    logic      consume;
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;

    decode_if   dec_bus ();
    reg_read_if rd_bus ();

    inst_buffer i_inst_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .consume    (consume),
        .halted     (halted),
        .buf_valid  (buf_valid),
        .buf_inst   (buf_inst)
    );

    idu i_idu (
        .buf_valid (buf_valid),
        .buf_inst  (buf_inst),
        .rd        (rd_bus.dec),
        .dec       (dec_bus.src)
    );

    regfile i_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (rd_bus.rf),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata)
    );

    exu i_exu (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec      (dec_bus.snk),
        .consume  (consume),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata),
        .wb_valid (wb_valid),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .halted   (halted)
    );

endmodule

`default_nettype wire

// ==== core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_props (
    input logic                clk,
    input logic                rst_n,
    input logic                inst_ready,
    input logic                wb_valid,
    input core_pkg::reg_addr_t wb_addr,
    input logic                halted
);

    int unsigned prop_errors = 0; // Read by the testbench at the end of the run.

    a_no_retire_after_halt: assert property (
        @(posedge clk) disable iff (!rst_n) $past(halted) |-> !wb_valid
    ) else begin
        $error("wb_valid high after the core had halted");
        prop_errors++;
    end

    a_halt_blocks_input: assert property (
        @(posedge clk) disable iff (!rst_n) halted |-> !inst_ready
    ) else begin
        $error("inst_ready high while halted");
        prop_errors++;
    end

    // x0 writes are dropped before the retire port.
    a_no_x0_retire: assert property (
        @(posedge clk) disable iff (!rst_n) wb_valid |-> (wb_addr != '0)
    ) else begin
        $error("retire reported for x0");
        prop_errors++;
    end

    a_ready_while_running: assert property (
        @(posedge clk) disable iff (!rst_n) !halted |-> inst_ready
    ) else begin
        $error("inst_ready low while the core runs");
        prop_errors++;
    end

endmodule

`default_nettype wire

// ==== tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import core_pkg::*;

    localparam int TIMEOUT     = 50; // Cycles for any single wait.
    localparam int HALT_WINDOW = 20;

    logic      clk;
    logic      rst_n;
    logic      inst_valid;
    inst_t     inst;
    logic      inst_ready;
    logic      wb_valid;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      halted;

    logic [31:0] lfsr;
    word_t       ref_regs [32];
    reg_addr_t   exp_addr_q [$];
    word_t       exp_data_q [$];
    reg_addr_t   exp_addr;
    word_t       exp_data;
    int          errors;
    int          expected_cnt;
    int          retired_cnt;

    core_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .halted     (halted)
    );

    bind core_top core_props i_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_ready (inst_ready),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .halted     (halted)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    task automatic report_counts();
        $display("errors: checks=%0d assertions=%0d, retired %0d of %0d expected writes",
                 errors, i_dut.i_props.prop_errors, retired_cnt, expected_cnt);
    endtask

    task automatic stop_on_timeout(input string what);
        $display("%0t: timeout while %s", $time, what);
        report_counts();
        $display("RESULT: FAIL");
        $finish;
    endtask

    // Called just after a falling edge. Returns one falling edge after the transfer.
    task automatic send_inst(input inst_t instr, input logic wr, input reg_addr_t rd,
                             input word_t val);
        int waited;
        waited     = 0;
        inst_valid = 1'b1;
        inst       = instr;
        while (!inst_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!inst_ready) begin
            stop_on_timeout("waiting for inst_ready");
        end else begin
            if (wr && rd != '0) begin
                ref_regs[rd] = val;
                exp_addr_q.push_back(rd);
                exp_data_q.push_back(val);
                expected_cnt++;
            end
            @(negedge clk);
        end
    endtask

    task automatic send_addi(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
        send_inst({imm, rs1, 3'b000, rd, 7'b0010011}, 1'b1, rd,
                  ref_regs[rs1] + {{20{imm[11]}}, imm});
    endtask

    task automatic send_add(input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
        send_inst({7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011}, 1'b1, rd,
                  ref_regs[rs1] + ref_regs[rs2]);
    endtask

    task automatic send_lui(input reg_addr_t rd, input logic [19:0] imm);
        send_inst({imm, rd, 7'b0110111}, 1'b1, rd, {imm, 12'b0});
    endtask

    task automatic send_nop(input inst_t instr);
        send_inst(instr, 1'b0, '0, '0);
    endtask

    task automatic send_random();
        logic [31:0] bits;
        logic [31:0] imm;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        bits = rand_bits(5);
        rd   = bits[4:0];
        bits = rand_bits(5);
        rs1  = bits[4:0];
        bits = rand_bits(2);
        case (bits[1:0])
            2'd0: begin
                imm = rand_bits(12);
                send_addi(rd, rs1, imm[11:0]);
            end
            2'd1: begin
                imm = rand_bits(5);
                rs2 = imm[4:0];
                send_add(rd, rs1, rs2);
            end
            2'd2: begin
                imm = rand_bits(20);
                send_lui(rd, imm[19:0]);
            end
            default: begin
                imm = rand_bits(12);
                send_nop({imm[11:0], rs1, 3'b010, rd, 7'b0010011}); // Undecoded slti.
            end
        endcase
    endtask

    task automatic idle(input int n);
        inst_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_addr_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_addr_q.size() != 0) begin
            stop_on_timeout("waiting for pending retires");
        end
    endtask

    task automatic check_halt();
        int waited;
        waited = 0;
        send_nop(32'h0010_0073); // ebreak
        inst_valid = 1'b0;
        while (!halted && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!halted) begin
            stop_on_timeout("waiting for halted after ebreak");
        end else begin
            inst_valid = 1'b1;
            inst       = {12'd1, 5'd0, 3'b000, 5'd1, 7'b0010011}; // addi x1, x0, 1
            repeat (HALT_WINDOW) begin
                @(negedge clk);
                assert (halted) else begin
                    $display("%0t: halted dropped after ebreak", $time);
                    errors++;
                end
                assert (!inst_ready) else begin
                    $display("%0t: inst_ready high after halt", $time);
                    errors++;
                end
            end
            inst_valid = 1'b0;
        end
    endtask

    // Retire port against the oldest expected write.
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            retired_cnt++;
            assert (exp_addr_q.size() != 0) begin
                exp_addr = exp_addr_q.pop_front();
                exp_data = exp_data_q.pop_front();
                assert (wb_addr == exp_addr) else begin
                    $display("MISMATCH %0t wb_addr expected %0d got %0d",
                             $time, exp_addr, wb_addr);
                    errors++;
                end
                assert (wb_data == exp_data) else begin
                    $display("MISMATCH %0t wb_data expected %h got %h",
                             $time, exp_data, wb_data);
                    errors++;
                end
            end else begin
                $display("%0t: retire of x%0d with no write expected", $time, wb_addr);
                errors++;
            end
        end
    end

    initial begin
        logic [31:0] bits;
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        lfsr         = 32'h2971;
        errors       = 0;
        expected_cnt = 0;
        retired_cnt  = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Dependent chain with inst_valid held high.
        send_addi(5'd1, 5'd0, 12'd5);
        send_add(5'd2, 5'd1, 5'd1);
        send_addi(5'd3, 5'd2, 12'hfff);
        send_add(5'd4, 5'd3, 5'd2);
        send_lui(5'd5, 20'habcde);
        send_add(5'd5, 5'd5, 5'd4);
        send_addi(5'd6, 5'd5, 12'h800);
        idle(2);
        drain();

        // Writes to x0 and encodings outside the subset.
        send_addi(5'd0, 5'd1, 12'd7);
        send_add(5'd0, 5'd2, 5'd3);
        send_nop(32'h0000_2083); // lw x1, 0(x0)
        send_nop({7'b0100000, 5'd2, 5'd1, 3'b000, 5'd7, 7'b0110011}); // sub
        send_add(5'd7, 5'd0, 5'd6);
        send_add(5'd8, 5'd6, 5'd0);
        idle(2);
        drain();

        repeat (200) send_random();
        idle(2);
        drain();

        // Random gaps in inst_valid.
        repeat (200) begin
            bits = rand_bits(2);
            if (bits[1:0] == 2'd0) begin
                bits = rand_bits(2);
                idle(bits[1:0] + 1);
            end
            send_random();
        end
        idle(2);
        drain();

        check_halt();

        assert (retired_cnt == expected_cnt) else begin
            $display("MISMATCH %0t retire_count expected %0d got %0d",
                     $time, expected_cnt, retired_cnt);
            errors++;
        end
        report_counts();
        if (errors == 0 && i_dut.i_props.prop_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
core_pkg.sv
core_ifs.sv
inst_buffer.sv
idu.sv
regfile.sv
exu.sv
core_top.sv
core_props.sv
tb_core.sv
